/* hw/fetch_pkg.sv */
package fetch_pkg;

  // Address and data width of the fetch path
  localparam int XLEN = 32;

  // First fetch address once reset is released
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;

  // Next-PC source codes
  // Sequential is the idle code, so a cleared pending register means PC + 4
  typedef enum logic [1:0] {
    PC_SEL_SEQ   = 2'b00,
    PC_SEL_PRED  = 2'b01,
    PC_SEL_REDIR = 2'b10
  } pc_sel_t;

  // Control-flow event from execute (redirect) or decode (static prediction)
  // Both are single-cycle pulses qualified by valid
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

  // Fetch request from the PC stage to the bus master
  // discard marks a word that belongs to a path already abandoned
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            discard;
  } fetch_req_t;

  // Fetched instruction with the address it came from
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } fetch_rsp_t;

endpackage

/* hw/pc_select.sv */
`timescale 1ns/1ps

module pc_select (
  input  logic                             clk,
  input  logic                             rst_n,
  input  fetch_pkg::redirect_t             redirect_i,
  input  fetch_pkg::redirect_t             pred_i,
  input  logic                             consume_i,
  output fetch_pkg::pc_sel_t               pc_sel_o,
  output logic [fetch_pkg::XLEN-1:0]       target_o,
  output logic                             flush_o
);

  // Pending source and its target, held until the PC stage takes them
  fetch_pkg::pc_sel_t              sel_q;
  logic [fetch_pkg::XLEN-1:0]      tgt_q;
  logic                            redir_take;
  logic                            pred_take;

  // A redirect always wins, and a newer one replaces an older one
  assign redir_take = redirect_i.valid;

  // Prediction only lands when no redirect is pending or arriving
  // A prediction behind a pending redirect comes from the wrong path
  assign pred_take = pred_i.valid && !redirect_i.valid &&
                     (sel_q != fetch_pkg::PC_SEL_REDIR);

  // Source register
  // A new event in the consume cycle survives the consume
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel_q <= fetch_pkg::PC_SEL_SEQ;
    end else if (redir_take) begin
      sel_q <= fetch_pkg::PC_SEL_REDIR;
    end else if (pred_take) begin
      sel_q <= fetch_pkg::PC_SEL_PRED;
    end else if (consume_i) begin
      sel_q <= fetch_pkg::PC_SEL_SEQ;
    end
  end

  // Target only matters while sel_q is not sequential
  always_ff @(posedge clk) begin
    if (redir_take) begin
      tgt_q <= redirect_i.target;
    end else if (pred_take) begin
      tgt_q <= pred_i.target;
    end
  end

  assign pc_sel_o = sel_q;
  assign target_o = tgt_q;

  // Any accepted event makes the words now in flight stale
  assign flush_o = redir_take || pred_take;

endmodule

/* hw/pc_stage.sv */
`timescale 1ns/1ps

module pc_stage (
  input  logic                             clk,
  input  logic                             rst_n,
  input  fetch_pkg::pc_sel_t               pc_sel_i,
  input  logic [fetch_pkg::XLEN-1:0]       target_i,
  input  logic                             flush_i,
  input  logic                             req_ready_i,
  output fetch_pkg::fetch_req_t            req_o,
  output logic                             req_valid_o,
  output logic                             consume_o
);

  // Current fetch address
  logic [fetch_pkg::XLEN-1:0] pc_q;

  // Address loaded on the next accept
  logic [fetch_pkg::XLEN-1:0] pc_next;

  // Request valid, low only during reset and the cycle it is released
  logic req_valid_q;

  // Handshake with the bus master
  logic accept;

  // Current PC is on the old path while an event waits
  logic stale;

  // Next-PC mux
  // Redirect and prediction both jump to the pending target
  always_comb begin
    case (pc_sel_i)
      fetch_pkg::PC_SEL_REDIR: pc_next = target_i;
      fetch_pkg::PC_SEL_PRED:  pc_next = target_i;
      fetch_pkg::PC_SEL_SEQ:   pc_next = pc_q + 'd4;
      default:                 pc_next = pc_q + 'd4;
    endcase
  end

  // Request issue
  // The PC stage always has an address to offer once out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= 1'b1;
    end
  end

  assign req_valid_o = req_valid_q;

  // Accept rule, both sides high in the same cycle
  assign accept = req_valid_q && req_ready_i;

  // PC register
  // Advances only on accept, so a refused request is offered again
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= fetch_pkg::RESET_PC;
    end else if (accept) begin
      pc_q <= pc_next;
    end
  end

  // Pending event is used up by the same accept that loads its target
  assign consume_o = accept;

  // Pending source means pc_q was computed before the event landed
  assign stale = (pc_sel_i != fetch_pkg::PC_SEL_SEQ);

  // Discard covers two cases
  // an event that waits for this accept, or one that arrives with it
  // In the second case the pending register takes the event only now,
  // so the following request is also marked through stale
  assign req_o = '{
    pc:      pc_q,
    discard: stale || flush_i
  };

endmodule

/* hw/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     advance_i,
  input  logic     hold_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output payload_t data_o,
  output logic     valid_o
);

  payload_t data_q;
  logic     valid_q;

  // Valid flag
  // Held stage keeps its item, otherwise it loads or drains
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (!hold_i) begin
      valid_q <= advance_i && valid_i;
    end
  end

  // Payload moves only with an advance, so a drained stage keeps old data
  always_ff @(posedge clk) begin
    if (!hold_i && advance_i) begin
      data_q <= data_i;
    end
  end

  assign data_o  = data_q;
  assign valid_o = valid_q;

endmodule

/* hw/fetch_wb.sv */
`timescale 1ns/1ps

module fetch_wb (
  input  logic                             clk,
  input  logic                             rst_n,
  input  fetch_pkg::fetch_req_t            req_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic                             flush_i,
  input  logic                             out_hold_i,
  output logic                             wb_cyc_o,
  output logic                             wb_stb_o,
  output logic                             wb_we_o,
  output logic [fetch_pkg::XLEN-1:0]       wb_adr_o,
  input  logic [fetch_pkg::XLEN-1:0]       wb_dat_i,
  input  logic                             wb_ack_i,
  output fetch_pkg::fetch_rsp_t            rsp_o,
  output logic                             rsp_valid_o
);

  typedef enum logic {
    ST_IDLE,
    ST_BUS
  } state_t;

  state_t                     state_q;
  logic [fetch_pkg::XLEN-1:0] adr_q;
  logic                       discard_q;
  logic                       accept;
  logic                       ack_keep;

  // Idle, and the output can take a result
  // The stage drains on accept, so a word acked later always finds room
  assign req_ready_o = (state_q == ST_IDLE) && !out_hold_i;
  assign accept      = req_valid_i && req_ready_o;

  // Ack of a word still on the live path
  assign ack_keep = (state_q == ST_BUS) && wb_ack_i && !discard_q && !flush_i;

  // Bus FSM
  // cyc drops the cycle after ack, so the next request waits one more cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= ST_IDLE;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q   <= ST_BUS;
            discard_q <= req_i.discard;
          end
        end
        ST_BUS: begin
          if (wb_ack_i) begin
            state_q <= ST_IDLE;
          end else if (flush_i) begin
            discard_q <= 1'b1;
          end
        end
      endcase
    end
  end

  // Address stays put from accept until the ack
  always_ff @(posedge clk) begin
    if (accept) begin
      adr_q <= req_i.pc;
    end
  end

  // Read-only master, stb follows cyc for single transfers
  assign wb_cyc_o = (state_q == ST_BUS);
  assign wb_stb_o = (state_q == ST_BUS);
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = adr_q;

  assign rsp_valid_o = ack_keep;
  assign rsp_o = '{
    pc:    adr_q,
    instr: wb_dat_i
  };

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  fetch_pkg::redirect_t             redirect_i,
  input  fetch_pkg::redirect_t             pred_i,
  input  logic                             stall_i,
  output fetch_pkg::fetch_rsp_t            fetch_o,
  output logic                             fetch_valid_o,
  output logic                             wb_cyc_o,
  output logic                             wb_stb_o,
  output logic                             wb_we_o,
  output logic [fetch_pkg::XLEN-1:0]       wb_adr_o,
  input  logic [fetch_pkg::XLEN-1:0]       wb_dat_i,
  input  logic                             wb_ack_i
);

  fetch_pkg::pc_sel_t         pc_sel;
  logic [fetch_pkg::XLEN-1:0] target;
  logic                       flush;
  logic                       consume;
  fetch_pkg::fetch_req_t      req;
  logic                       req_valid;
  logic                       req_ready;
  fetch_pkg::fetch_rsp_t      rsp;
  logic                       rsp_valid;
  // Output full and decode not taking it
  logic                       out_hold;
  logic                       stage_adv;

  assign out_hold  = stall_i && fetch_valid_o;
  assign stage_adv = rsp_valid && !out_hold;

  pc_select u_pc_select (
    .clk       (clk),
    .rst_n     (rst_n),
    .redirect_i(redirect_i),
    .pred_i    (pred_i),
    .consume_i (consume),
    .pc_sel_o  (pc_sel),
    .target_o  (target),
    .flush_o   (flush)
  );

  pc_stage u_pc_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_sel_i   (pc_sel),
    .target_i   (target),
    .flush_i    (flush),
    .req_ready_i(req_ready),
    .req_o      (req),
    .req_valid_o(req_valid),
    .consume_o  (consume)
  );

  fetch_wb u_fetch_wb (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req),
    .req_valid_i(req_valid),
    .req_ready_o(req_ready),
    .flush_i    (flush),
    .out_hold_i (out_hold),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_we_o    (wb_we_o),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i),
    .rsp_o      (rsp),
    .rsp_valid_o(rsp_valid)
  );

  // Registered hand-off to decode
  stage_reg #(
    .payload_t(fetch_pkg::fetch_rsp_t)
  ) u_out_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(stage_adv),
    .hold_i   (out_hold),
    .data_i   (rsp),
    .valid_i  (rsp_valid),
    .data_o   (fetch_o),
    .valid_o  (fetch_valid_o)
  );

endmodule

/* bench/fetch_asserts.sv */
`timescale 1ns/1ps

module fetch_asserts (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        cyc_i,
  input logic                        stb_i,
  input logic                        we_i,
  input logic [fetch_pkg::XLEN-1:0]  adr_i,
  input logic                        ack_i,
  input logic                        stall_i,
  input fetch_pkg::fetch_rsp_t       out_i,
  input logic                        out_valid_i
);

  // Failures seen so far, polled by the testbench every cycle
  int fail_count = 0;

  // stb only inside a bus cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    stb_i |-> cyc_i)
  else begin
    $error("wb_stb_o high without wb_cyc_o");
    fail_count++;
  end

  // Read-only master
  a_read_only: assert property (@(posedge clk) disable iff (!rst_n)
    cyc_i |-> !we_i)
  else begin
    $error("wb_we_o high during a bus cycle");
    fail_count++;
  end

  // Strobe and address hold until the slave acks
  a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (cyc_i && stb_i && !ack_i) |=> (cyc_i && stb_i && $stable(adr_i)))
  else begin
    $error("Wishbone request dropped or address moved before ack");
    fail_count++;
  end

  // Cycle ends right after the ack
  a_cyc_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (cyc_i && ack_i) |=> !cyc_i)
  else begin
    $error("wb_cyc_o still high after ack");
    fail_count++;
  end

  // Decode stalled, so the output word must wait unchanged
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid_i && stall_i) |=> (out_valid_i && $stable(out_i)))
  else begin
    $error("fetch_o changed while stalled");
    fail_count++;
  end

endmodule

bind fetch_top fetch_asserts u_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .cyc_i      (wb_cyc_o),
  .stb_i      (wb_stb_o),
  .we_i       (wb_we_o),
  .adr_i      (wb_adr_o),
  .ack_i      (wb_ack_i),
  .stall_i    (stall_i),
  .out_i      (fetch_o),
  .out_valid_i(fetch_valid_o)
);

/* bench/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

  logic                       clk = 1'b0;
  logic                       rst_n = 1'b0;
  fetch_pkg::redirect_t       redirect_i = '0;
  fetch_pkg::redirect_t       pred_i = '0;
  logic                       stall_i = 1'b0;
  logic [31:0]                wb_dat_i = '0;
  logic                       wb_ack_i = 1'b0;
  fetch_pkg::fetch_rsp_t      fetch_o;
  logic                       fetch_valid_o;
  logic                       wb_cyc_o;
  logic                       wb_stb_o;
  logic                       wb_we_o;
  logic [31:0]                wb_adr_o;

  // Raw words of the data file
  logic [31:0] stim [0:63];
  logic [5:0]  ev_ptr = 6'd2;
  logic [5:0]  exp_ptr;
  int          ev_left;
  int          n_expected;
  int          delivered = 0;
  int          cycles = 0;
  int          timeout_limit;

  // Bus model state
  logic [31:0] lfsr = 32'hc9e119d5;
  logic        armed = 1'b0;
  logic [1:0]  wait_left = 2'd0;

  fetch_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect_i),
    .pred_i       (pred_i),
    .stall_i      (stall_i),
    .fetch_o      (fetch_o),
    .fetch_valid_o(fetch_valid_o),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i)
  );

  always #5 clk = ~clk;

  // Fibonacci step, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [1:0] bits);
    bits = 2'b00;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[0], lfsr[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    if (got !== want) begin
      abort_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want));
    end
  endtask

  // Last word seen, bound protocol checks decide the verdict
  task automatic finish_run();
    if (DUT.u_asserts.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run($sformatf("%0d protocol assertions failed", DUT.u_asserts.fail_count));
    end
  endtask

  initial begin
    $readmemh("bench/fetch_input.txt", stim);
    ev_left       = stim[0];
    n_expected    = stim[1];
    exp_ptr       = 6'(2 + 3 * ev_left);
    timeout_limit = 8 * n_expected + 50;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

  // Wishbone slave with 0 to 3 wait states, and decode stall at about 25 %
  always @(posedge clk) begin : bus_model
    logic [1:0] bits;
    draw_bits(2, bits);
    stall_i <= (bits == 2'b00);
    if (wb_ack_i) begin
      wb_ack_i <= 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!armed) begin
        armed = 1'b1;
        draw_bits(2, bits);
        wait_left = bits;
      end
      if (wait_left == 2'd0) begin
        wb_ack_i <= 1'b1;
        wb_dat_i <= wb_adr_o ^ 32'h5a5a_0000;
        armed = 1'b0;
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  end

  // Delivery check and event pulses
  // An event fires on the edge its delivered count is reached, one per edge
  always @(posedge clk) begin : monitor
    logic [31:0] want;
    want = stim[exp_ptr];
    redirect_i <= '0;
    pred_i     <= '0;
    cycles = cycles + 1;
    if (cycles > timeout_limit) begin
      abort_run($sformatf("Timeout: only %0d of %0d instructions delivered in %0d cycles",
                          delivered, n_expected, cycles));
    end else if (DUT.u_asserts.fail_count != 0) begin
      abort_run($sformatf("%0d protocol assertions failed", DUT.u_asserts.fail_count));
    end else begin
      // Decode takes the word when valid and not stalled
      if (fetch_valid_o && !stall_i) begin
        compare_word("fetch_o.pc", fetch_o.pc, want);
        compare_word("fetch_o.instr", fetch_o.instr, want ^ 32'h5a5a_0000);
        delivered = delivered + 1;
        exp_ptr = exp_ptr + 6'd1;
      end
      if (delivered == n_expected) begin
        finish_run();
      end else if (ev_left != 0 && stim[ev_ptr] == delivered) begin
        // Kind 1 is a redirect from execute, anything else a prediction
        if (stim[ev_ptr + 6'd1] == 32'd1) begin
          redirect_i <= '{valid: 1'b1, target: stim[ev_ptr + 6'd2]};
        end else begin
          pred_i <= '{valid: 1'b1, target: stim[ev_ptr + 6'd2]};
        end
        ev_ptr = ev_ptr + 6'd3;
        ev_left = ev_left - 1;
      end
    end
  end

endmodule

/* src.f */
hw/fetch_pkg.sv
hw/pc_select.sv
hw/pc_stage.sv
hw/stage_reg.sv
hw/fetch_wb.sv
hw/fetch_top.sv
bench/fetch_asserts.sv
bench/fetch_tb.sv

/* Makefile */
TOP = fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

# The run passes only when the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/fetch_input.txt */
// Word 0 number of events, word 1 number of expected PCs
// Event rows: delivered count to pulse at, kind (1 redirect, 2 prediction), target
// Then the expected delivered PCs in order, four per row
00000007 00000018
00000005 00000001 00000200
00000008 00000002 00000300
0000000c 00000002 00000400
0000000c 00000001 00000500
0000000f 00000001 00001000
00000014 00000001 00000600
00000014 00000001 00000680
00000100 00000104 00000108 0000010c
00000110 00000200 00000204 00000208
00000300 00000304 00000308 0000030c
00000500 00000504 00000508 00001000
00001004 00001008 0000100c 00001010
00000680 00000684 00000688 0000068c
